/* design/cmd_dispatch.sv */
`include "hl2_defs.svh"

module cmd_dispatch (
  input  logic             clk_ctrl,
  input  logic             rst_n_i,
  input  hl2_pkg::cmd_t    cmd_i,
  input  logic             cmd_req_i,
  output logic             cmd_ack_o,
  output hl2_pkg::cmd_t    bcast_cmd_o,
  output logic             bcast_wr_o,
  output logic             run_o,
  output hl2_pkg::rdback_t gen_rdback_o,
  output logic             rsp_start_o,
  input  logic             rsp_busy_i
);

  typedef enum logic [1:0] {
    st_idle,
    st_cap,
    st_wr,
    st_ack
  } state_e;

  state_e        state_q;
  state_e        state_d;
  hl2_pkg::cmd_t cmd_q;
  logic          run_q;
  logic          rsp_start_q;
  logic          gen_hit;

  ////////////////////////////////////////
  // command side four-phase handshake

  always_comb begin
    state_d = state_q;
    case (state_q)
      st_idle: begin
        // no capture while the last response is still out
        if (cmd_req_i && !rsp_busy_i) begin
          state_d = st_cap;
        end
      end
      st_cap: begin
        state_d = st_wr;
      end
      st_wr: begin
        state_d = st_ack;
      end
      st_ack: begin
        if (!cmd_req_i) begin
          state_d = st_idle;
        end
      end
      default: begin
        state_d = st_idle;
      end
    endcase
  end

  always_ff @(posedge clk_ctrl or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q     <= st_idle;
      run_q       <= 1'b0;
      rsp_start_q <= 1'b0;
    end else begin
      state_q     <= state_d;
      // registers take effect at the end of the strobe cycle
      if (state_q == st_wr && gen_hit) begin
        run_q <= cmd_q.data[0];
      end
      rsp_start_q <= (state_q == st_wr) && cmd_q.resp_rqst;
    end
  end

  // command word held for the whole broadcast
  always_ff @(posedge clk_ctrl) begin
    if (state_q == st_idle && state_d == st_cap) begin
      cmd_q <= cmd_i;
    end
  end

  ////////////////////////////////////////
  // broadcast and general register

  assign gen_hit      = (cmd_q.addr == `HL2_ADDR_GEN);
  assign bcast_cmd_o  = cmd_q;
  assign bcast_wr_o   = (state_q == st_wr);
  assign cmd_ack_o    = (state_q == st_ack);
  assign run_o        = run_q;
  assign rsp_start_o  = rsp_start_q;
  assign gen_rdback_o = gen_hit ? {{(`HL2_DATA_W-1){1'b0}}, run_q} : '0;

  ack_needs_req_a: assert property (
    @(posedge clk_ctrl) disable iff (!rst_n_i)
    $rose(cmd_ack_o) |-> cmd_req_i
  );

  // one write per command
  wr_one_cycle_a: assert property (
    @(posedge clk_ctrl) disable iff (!rst_n_i)
    bcast_wr_o |=> !bcast_wr_o
  );

endmodule

/* design/hl2_cmd_core.sv */
`include "hl2_defs.svh"

module hl2_cmd_core (
  input  logic              clk_ctrl,
  input  logic              rst_n_i,
  // host command port
  input  hl2_pkg::cmd_t     cmd_i,
  input  logic              cmd_req_i,
  output logic              cmd_ack_o,
  // host response port
  output hl2_pkg::resp_t    resp_o,
  output logic              resp_req_o,
  input  logic              resp_ack_i,
  // local oscillator signs, one per receiver
  output logic [`HL2_NR-1:0] lo_sign_o
);

  hl2_pkg::cmd_t    bcast_cmd;
  logic             bcast_wr;
  logic             run;
  hl2_pkg::rdback_t gen_rdback;
  hl2_pkg::rdback_t slot_rdback [`HL2_NR];
  logic             rsp_start;
  logic             rsp_busy;

  ////////////////////////////////////////
  // command dispatch

  cmd_dispatch cmd_dispatch_i (
    .clk_ctrl     (clk_ctrl),
    .rst_n_i      (rst_n_i),
    .cmd_i        (cmd_i),
    .cmd_req_i    (cmd_req_i),
    .cmd_ack_o    (cmd_ack_o),
    .bcast_cmd_o  (bcast_cmd),
    .bcast_wr_o   (bcast_wr),
    .run_o        (run),
    .gen_rdback_o (gen_rdback),
    .rsp_start_o  (rsp_start),
    .rsp_busy_i   (rsp_busy)
  );

  ////////////////////////////////////////
  // receiver slots

  for (genvar i = 0; i < `HL2_NR; i++) begin : g_slot
    rx_nco_slot #(
      .SLOT_IDX (i)
    ) rx_nco_slot_i (
      .clk_ctrl    (clk_ctrl),
      .rst_n_i     (rst_n_i),
      .bcast_cmd_i (bcast_cmd),
      .bcast_wr_i  (bcast_wr),
      .run_i       (run),
      .rdback_o    (slot_rdback[i]),
      .lo_sign_o   (lo_sign_o[i])
    );
  end

  ////////////////////////////////////////
  // response collector

  resp_collect #(
    .NSLOT (`HL2_NR)
  ) resp_collect_i (
    .clk_ctrl      (clk_ctrl),
    .rst_n_i       (rst_n_i),
    .bcast_cmd_i   (bcast_cmd),
    .slot_rdback_i (slot_rdback),
    .gen_rdback_i  (gen_rdback),
    .rsp_start_i   (rsp_start),
    .rsp_busy_o    (rsp_busy),
    .resp_o        (resp_o),
    .resp_req_o    (resp_req_o),
    .resp_ack_i    (resp_ack_i)
  );

endmodule

/* design/hl2_defs.svh */
`ifndef HL2_DEFS_SVH
`define HL2_DEFS_SVH

////////////////////////////////////////
// receiver count

`define HL2_NR 4

////////////////////////////////////////
// command field widths

`define HL2_ADDR_W 6
`define HL2_DATA_W 32

////////////////////////////////////////
// address map

// general register, bit 0 is run
`define HL2_ADDR_GEN 6'h00
// receiver i frequency word sits at base plus i
`define HL2_ADDR_RX_BASE 6'h02

`endif

/* design/hl2_pkg.sv */
`include "hl2_defs.svh"

package hl2_pkg;

  ////////////////////////////////////////
  // command path types

  // one host command as it arrives on the command port
  typedef struct packed {
    logic [`HL2_ADDR_W-1:0] addr;
    logic [`HL2_DATA_W-1:0] data;
    logic                   resp_rqst;
  } cmd_t;

  // response back to the host, addr echoes the command
  typedef struct packed {
    logic [`HL2_ADDR_W-1:0] addr;
    logic [`HL2_DATA_W-1:0] data;
  } resp_t;

  // register value of one owner, zero when not addressed
  typedef logic [`HL2_DATA_W-1:0] rdback_t;

endpackage

/* design/resp_collect.sv */
module resp_collect #(
  parameter int NSLOT = 4
) (
  input  logic             clk_ctrl,
  input  logic             rst_n_i,
  input  hl2_pkg::cmd_t    bcast_cmd_i,
  input  hl2_pkg::rdback_t slot_rdback_i [NSLOT],
  input  hl2_pkg::rdback_t gen_rdback_i,
  input  logic             rsp_start_i,
  output logic             rsp_busy_o,
  output hl2_pkg::resp_t   resp_o,
  output logic             resp_req_o,
  input  logic             resp_ack_i
);

  typedef enum logic [1:0] {
    st_idle,
    st_req,
    st_drop
  } state_e;

  state_e           state_q;
  hl2_pkg::rdback_t merged;
  hl2_pkg::resp_t   resp_q;

  ////////////////////////////////////////
  // readback merge

  // at most one owner answers, so OR is a mux
  always_comb begin
    merged = gen_rdback_i;
    for (int i = 0; i < NSLOT; i++) begin
      merged = merged | slot_rdback_i[i];
    end
  end

  always_ff @(posedge clk_ctrl) begin
    if (state_q == st_idle && rsp_start_i) begin
      resp_q.addr <= bcast_cmd_i.addr;
      resp_q.data <= merged;
    end
  end

  ////////////////////////////////////////
  // response side four-phase handshake

  always_ff @(posedge clk_ctrl or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= st_idle;
    end else begin
      case (state_q)
        st_idle: begin
          if (rsp_start_i) begin
            state_q <= st_req;
          end
        end
        st_req: begin
          if (resp_ack_i) begin
            state_q <= st_drop;
          end
        end
        st_drop: begin
          // busy until the host has released ack
          if (!resp_ack_i) begin
            state_q <= st_idle;
          end
        end
        default: begin
          state_q <= st_idle;
        end
      endcase
    end
  end

  assign resp_o     = resp_q;
  assign resp_req_o = (state_q == st_req);
  assign rsp_busy_o = rsp_start_i || (state_q != st_idle);

  resp_stable_a: assert property (
    @(posedge clk_ctrl) disable iff (!rst_n_i)
    resp_req_o && $past(resp_req_o) |-> $stable(resp_o)
  );

endmodule

/* design/rx_nco_slot.sv */
`include "hl2_defs.svh"

module rx_nco_slot #(
  parameter int SLOT_IDX = 0
) (
  input  logic             clk_ctrl,
  input  logic             rst_n_i,
  input  hl2_pkg::cmd_t    bcast_cmd_i,
  input  logic             bcast_wr_i,
  input  logic             run_i,
  output hl2_pkg::rdback_t rdback_o,
  output logic             lo_sign_o
);

  localparam int unsigned SLOT_ADDR_INT = `HL2_ADDR_RX_BASE + SLOT_IDX;
  localparam logic [`HL2_ADDR_W-1:0] SLOT_ADDR = SLOT_ADDR_INT[`HL2_ADDR_W-1:0];

  logic                   addr_hit;
  logic [`HL2_DATA_W-1:0] freq_q;
  logic [`HL2_DATA_W-1:0] phase_q;

  assign addr_hit = (bcast_cmd_i.addr == SLOT_ADDR);

  ////////////////////////////////////////
  // frequency word and phase accumulator

  always_ff @(posedge clk_ctrl or negedge rst_n_i) begin
    if (!rst_n_i) begin
      freq_q  <= '0;
      phase_q <= '0;
    end else begin
      if (bcast_wr_i && addr_hit) begin
        freq_q <= bcast_cmd_i.data;
      end
      // accumulator parked at zero when not running
      if (run_i) begin
        phase_q <= phase_q + freq_q;
      end else begin
        phase_q <= '0;
      end
    end
  end

  // sign of the local oscillator
  assign lo_sign_o = phase_q[`HL2_DATA_W-1];

  assign rdback_o = addr_hit ? freq_q : '0;

  freq_hold_a: assert property (
    @(posedge clk_ctrl) disable iff (!rst_n_i)
    !(bcast_wr_i && addr_hit) |=> $stable(freq_q)
  );

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the command core testbench with Verilator

cd "$(dirname "$0")" || exit 1

TOP=tb_hl2_cmd_core
OBJ_DIR=obj_dir
LOG=sim.log
FAIL_MSG='\*\*\* FAILED \*\*\*'

echo "building ${TOP}"
verilator --binary --timing --assert -f vlog.f --top-module "${TOP}" -Mdir "${OBJ_DIR}"
build_status=$?
if [ ${build_status} -ne 0 ]; then
  echo "build failed with status ${build_status}"
  exit 1
fi

echo "running ${TOP}"
"./${OBJ_DIR}/V${TOP}" > "${LOG}" 2>&1
run_status=$?
cat "${LOG}"

if grep -q "${FAIL_MSG}" "${LOG}"; then
  echo "simulation reported a failure"
  exit 1
fi

if [ ${run_status} -ne 0 ]; then
  echo "simulation exited with status ${run_status}"
  exit 1
fi

if ! grep -q '\*\*\* PASSED \*\*\*' "${LOG}"; then
  echo "simulation ended without a result"
  exit 1
fi

echo "simulation passed"
exit 0

/* sim/cmd_stim.txt */
# columns: op addr(hex) data(hex) resp(0 none, 1 response, 2 response with late ack) expected(hex)
# lo lines: data is the mask of slots that must toggle, expected is the level of the others
# state right after reset
lo 00 00000000 0 00000000
# frequency words echo back through the response
wr 02 12345678 1 12345678
wr 03 9abcdef0 1 9abcdef0
wr 04 0badf00d 1 0badf00d
wr 05 deadbeef 1 deadbeef
# general register returns run only
wr 00 00000003 1 00000001
wr 00 00000000 1 00000000
# known slot setup, the last two without a response
wr 02 80000000 1 80000000
wr 03 00000000 1 00000000
wr 04 00000000 0 00000000
wr 05 00000000 0 00000000
# unused addresses answer zero
wr 01 ffffffff 1 00000000
wr 3f ffffffff 1 00000000
wr 06 ffffffff 1 00000000
wr 07 ffffffff 0 00000000
# the write to 0x01 must not start run
lo 00 00000000 0 00000000
# run on, only slot 0 toggles so the other slots kept zero
wr 00 00000001 1 00000001
lo 00 00000001 0 00000000
wr 00 00000000 1 00000000
lo 00 00000000 0 00000000
# late response acks hold off the next command
wr 03 80000000 2 80000000
wr 04 00000001 1 00000001
wr 05 00000002 2 00000002
wr 02 00000000 0 00000000
wr 00 00000001 2 00000001
wr 05 00000000 1 00000000
# slot 1 toggles, slot 2 creeps up slowly and keeps sign zero
lo 00 00000002 0 00000000
wr 3f 00000000 2 00000000
lo 00 00000002 0 00000000
# run off clears every phase
wr 00 00000000 1 00000000
lo 00 00000000 0 00000000
# slot words still there after the run
wr 03 80000000 1 80000000
wr 04 00000001 1 00000001

/* sim/tb_hl2_cmd_core.sv */
`include "hl2_defs.svh"

module tb_hl2_cmd_core;

  localparam int CYCLES_PER_LINE = 20;
  localparam int CYCLE_MARGIN    = 100;
  localparam string STIM_FILE    = "sim/cmd_stim.txt";
  localparam logic [31:0] SEED   = 32'h80c9;

  // one line of the stimulus file
  typedef struct packed {
    logic                   is_lo;
    logic [`HL2_ADDR_W-1:0] addr;
    logic [`HL2_DATA_W-1:0] data;
    logic [1:0]             flag;
    logic [`HL2_DATA_W-1:0] exp;
  } op_t;

  // expected response and whether its ack comes late
  typedef struct packed {
    hl2_pkg::resp_t resp;
    logic           hold;
  } resp_exp_t;

  logic               clk_ctrl;
  logic               rst_n_i;
  hl2_pkg::cmd_t      cmd_i;
  logic               cmd_req_i;
  logic               cmd_ack_o;
  hl2_pkg::resp_t     resp_o;
  logic               resp_req_o;
  logic               resp_ack_i;
  logic [`HL2_NR-1:0] lo_sign_o;

  op_t         ops[$];
  resp_exp_t   exp_q[$];
  int          resp_exp_cnt  = 0;
  int          resp_done_cnt = 0;
  int          cycle_cnt     = 0;
  int          cycle_limit   = 1000;
  logic [31:0] rng_state     = SEED;

  hl2_cmd_core hl2_cmd_core_i (
    .clk_ctrl   (clk_ctrl),
    .rst_n_i    (rst_n_i),
    .cmd_i      (cmd_i),
    .cmd_req_i  (cmd_req_i),
    .cmd_ack_o  (cmd_ack_o),
    .resp_o     (resp_o),
    .resp_req_o (resp_req_o),
    .resp_ack_i (resp_ack_i),
    .lo_sign_o  (lo_sign_o)
  );

  initial begin
    clk_ctrl = 1'b0;
    forever #50 clk_ctrl = ~clk_ctrl;
  end

  ////////////////////////////////////////
  // helpers

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic stop_fail();
    $display("*** FAILED ***");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_eq(input logic [63:0] got, input logic [63:0] exp, input string what);
    if (got !== exp) begin
      $display("MISMATCH at %0t: %s, got %0h, expected %0h", $time, what, got, exp);
      stop_fail();
    end
  endtask

  task automatic load_stim();
    int          fd;
    int          n;
    string       line;
    logic [15:0] op_s;
    logic [31:0] a_v;
    logic [31:0] d_v;
    int          f_v;
    logic [31:0] e_v;
    op_t         op;
    fd = $fopen(STIM_FILE, "r");
    if (fd == 0) begin
      $display("ERROR: cannot open the stimulus file %s", STIM_FILE);
      stop_fail();
    end
    while (!$feof(fd)) begin
      line = "";
      void'($fgets(line, fd));
      if (line.len() > 0 && line.getc(0) != "#") begin
        n = $sscanf(line, "%s %h %h %d %h", op_s, a_v, d_v, f_v, e_v);
        if (n == 5 && (op_s == "wr" || op_s == "lo")) begin
          op.is_lo = (op_s == "lo");
          op.addr  = a_v[`HL2_ADDR_W-1:0];
          op.data  = d_v;
          op.flag  = f_v[1:0];
          op.exp   = e_v;
          ops.push_back(op);
        end else if (n > 0) begin
          $display("ERROR: the stimulus file has a line that cannot be read: %s", line);
          stop_fail();
        end
      end
    end
    $fclose(fd);
  endtask

  // one command through the four-phase port from a rising edge
  task automatic run_cmd(input op_t op);
    hl2_pkg::cmd_t c;
    resp_exp_t     e;
    int            done_before;
    done_before = resp_exp_cnt;
    c.addr      = op.addr;
    c.data      = op.data;
    c.resp_rqst = (op.flag != 2'd0);
    if (c.resp_rqst) begin
      e.resp.addr = op.addr;
      e.resp.data = op.exp;
      e.hold      = (op.flag == 2'd2);
      exp_q.push_back(e);
      resp_exp_cnt++;
    end
    cmd_i     <= c;
    cmd_req_i <= 1'b1;
    do @(posedge clk_ctrl); while (!cmd_ack_o);
    // the previous response must be finished before this ack
    check_eq(64'(resp_done_cnt), 64'(done_before), "responses finished at command ack");
    cmd_req_i <= 1'b0;
    do @(posedge clk_ctrl); while (cmd_ack_o);
  endtask

  // masked slots flip on every sample while the rest hold their level
  task automatic check_lo(input op_t op);
    logic [`HL2_NR-1:0] mask;
    logic [`HL2_NR-1:0] level;
    logic [`HL2_NR-1:0] prev;
    logic [`HL2_NR-1:0] cur;
    mask  = op.data[`HL2_NR-1:0];
    level = op.exp[`HL2_NR-1:0];
    @(posedge clk_ctrl);
    prev = lo_sign_o;
    repeat (8) begin
      @(posedge clk_ctrl);
      cur = lo_sign_o;
      check_eq(64'(cur & mask), 64'(~prev & mask), "lo_sign_o toggling slots");
      check_eq(64'(cur & ~mask), 64'(level & ~mask), "lo_sign_o steady slots");
      prev = cur;
    end
  endtask

  ////////////////////////////////////////
  // host answers each response request

  initial begin
    resp_exp_t   e;
    logic [3:0]  delay;
    forever begin
      @(posedge clk_ctrl);
      if (resp_req_o) begin
        if (exp_q.size() == 0) begin
          $display("ERROR: response request at %0t with no command waiting for one", $time);
          stop_fail();
        end
        e = exp_q.pop_front();
        check_eq(64'(resp_o.addr), 64'(e.resp.addr), "response addr");
        check_eq(64'(resp_o.data), 64'(e.resp.data), "response data");
        rng_state = xorshift32(rng_state);
        delay     = e.hold ? 4'd8 : {2'b00, rng_state[1:0]};
        repeat (delay) @(posedge clk_ctrl);
        resp_ack_i <= 1'b1;
        do @(posedge clk_ctrl); while (resp_req_o);
        resp_ack_i <= 1'b0;
        resp_done_cnt++;
      end
    end
  end

  // run limit from the number of stimulus lines
  always @(posedge clk_ctrl) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= cycle_limit) begin
      $display("ERROR: handshake timed out after %0d cycles", cycle_cnt);
      stop_fail();
    end
  end

  ////////////////////////////////////////
  // main sequence

  initial begin
    rst_n_i    = 1'b0;
    cmd_i      = '0;
    cmd_req_i  = 1'b0;
    resp_ack_i = 1'b0;
    load_stim();
    cycle_limit = CYCLES_PER_LINE * ops.size() + CYCLE_MARGIN;
    repeat (4) @(posedge clk_ctrl);
    rst_n_i <= 1'b1;
    repeat (2) @(posedge clk_ctrl);
    check_eq(64'(cmd_ack_o), 64'd0, "cmd_ack_o after reset");
    check_eq(64'(resp_req_o), 64'd0, "resp_req_o after reset");
    check_eq(64'(lo_sign_o), 64'd0, "lo_sign_o after reset");
    foreach (ops[i]) begin
      if (ops[i].is_lo) begin
        check_lo(ops[i]);
      end else begin
        run_cmd(ops[i]);
      end
    end
    // let the last response drain
    while (resp_done_cnt != resp_exp_cnt) begin
      @(posedge clk_ctrl);
    end
    repeat (4) @(posedge clk_ctrl);
    check_eq(64'(resp_req_o), 64'd0, "resp_req_o at the end");
    $display("*** PASSED ***");
    $finish;
  end

endmodule

/* vlog.f */
+incdir+design
design/hl2_pkg.sv
design/cmd_dispatch.sv
design/rx_nco_slot.sv
design/resp_collect.sv
design/hl2_cmd_core.sv
sim/tb_hl2_cmd_core.sv
